// File: all.f
+incdir+.
isa_pkg.sv
rs_pkg.sv
dispatch_if.sv
issue_if.sv
rename_dispatch.sv
reservation_station.sv
exec_units.sv
ooo_core_top.sv
ooo_core_props.sv
tb_ooo_core.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - rs_pkg.sv
      - dispatch_if.sv
      - issue_if.sv
      - rename_dispatch.sv
      - reservation_station.sv
      - exec_units.sv
      - ooo_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ooo_core_props.sv
      - tb_ooo_core.sv

// File: tb_ooo_core.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module tb_ooo_core;
  import isa_pkg::*;
  import rs_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 4;
  localparam int NUM_INSTS       = 400;
  localparam int CYCLES_PER_INST = 20;   // generous, mul bursts stall a lot

  logic     clock;
  logic     reset;
  logic     inst_valid;
  op_t      inst_op;
  reg_idx_t inst_dest;
  reg_idx_t inst_src1;
  reg_idx_t inst_src2;
  logic     inst_stall;
  tag_t     inst_tag;
  logic     cdb_valid;
  tag_t     cdb_tag;
  data_t    cdb_value;

  data_t    model_reg [`OOO_NUM_REGS];   // in-order architectural state
  int       seed       = 13;
  int       accepted   = 0;
  int       broadcasts = 0;

  ooo_core_top UUT (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_op    (inst_op),
    .inst_dest  (inst_dest),
    .inst_src1  (inst_src1),
    .inst_src2  (inst_src2),
    .inst_stall (inst_stall),
    .inst_tag   (inst_tag),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // result of one op in program order, wraps at 16 bits
  function automatic data_t in_order_result(op_t op, data_t a, data_t b);
    data_t r;
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_XOR:  r = a ^ b;
      default: r = a * b;   // low half of the product
    endcase
    return r;
  endfunction

  // hold one instruction until the core takes it
  task automatic send(op_t op, reg_idx_t dest, reg_idx_t src1, reg_idx_t src2);
    logic  taken;
    data_t result;
    taken      = 1'b0;
    inst_valid = 1'b1;
    inst_op    = op;
    inst_dest  = dest;
    inst_src1  = src1;
    inst_src2  = src2;
    while (!taken) begin
      @(negedge clock);                      // stall and tag settled here
      if (!inst_stall) begin
        taken  = 1'b1;
        result = in_order_result(op, model_reg[src1], model_reg[src2]);
        model_reg[dest] = result;
        UUT.u_props.expect_result(inst_tag, result);
        accepted++;
      end
      @(posedge clock);
      #1;
    end
    inst_valid = 1'b0;
  endtask

  always @(negedge clock) begin
    if (!reset && cdb_valid) broadcasts++;   // one result per cycle at most
  end

  initial begin
    int       rnd;
    op_t      op;
    reg_idx_t d;
    reg_idx_t s1;
    reg_idx_t s2;
    reg_idx_t last_dest;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst_op    = OP_ADD;
    inst_dest  = '0;
    inst_src1  = '0;
    inst_src2  = '0;
    last_dest  = '0;
    for (int r = 0; r < `OOO_NUM_REGS; r++) model_reg[r] = data_t'(r);
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NUM_INSTS; i++) begin
      rnd = $random(seed);
      s2  = reg_idx_t'(rnd[11:10]);          // four registers, lots of hazards
      d   = reg_idx_t'(rnd[1:0]);
      case ((i / 40) % 3)
        0: begin
          op = op_t'(rnd[6:4] % 3'd5);
          s1 = reg_idx_t'(rnd[9:8]);
        end
        1: begin                             // multiply burst, one mul entry
          op = OP_MUL;
          s1 = reg_idx_t'(rnd[9:8]);
        end
        default: begin                       // chain through the last result
          op = rnd[7] ? OP_MUL : op_t'(rnd[6:4] % 3'd5);
          s1 = last_dest;
        end
      endcase
      send(op, d, s1, s2);
      last_dest = d;
      if (rnd[15:13] == 3'b000) begin
        @(posedge clock);                    // bubble in the stream
        #1;
      end
    end
    wait (broadcasts == accepted);           // drain every tag
    repeat (8) @(posedge clock);
    if (UUT.u_props.err_count == 0 && broadcasts == accepted) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "%0d tags still outstanding at end of run", accepted - broadcasts);
    end
  end

  // first failed assertion ends the run
  initial begin
    wait (UUT.u_props.err_count != 0);
    $display("Done: errors found");
    $fatal(1, "an assertion in the core checks failed");
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_INSTS * CYCLES_PER_INST));
    $display("Done: errors found");
    $fatal(1, "timeout, %0d instructions accepted, %0d results broadcast",
           accepted, broadcasts);
  end

endmodule

// File: ooo_core_props.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module ooo_core_props (
  input logic           clock,
  input logic           reset,
  input logic           inst_valid,
  input logic           inst_stall,
  input rs_pkg::tag_t   inst_tag,
  input logic           cdb_valid,
  input rs_pkg::tag_t   cdb_tag,
  input isa_pkg::data_t cdb_value
);
  import isa_pkg::*;
  import rs_pkg::*;

  data_t                    exp_val [`OOO_NUM_TAGS];   // in-order result per tag
  logic [`OOO_NUM_TAGS-1:0] live;                      // accepted, not yet broadcast
  logic                     seen_accept;
  logic                     accept;
  int unsigned              err_count = 0;

  assign accept = inst_valid && !inst_stall;

  // written by the testbench model at each acceptance
  task automatic expect_result(tag_t tag, data_t value);
    exp_val[tag] = value;
  endtask

  function automatic bit value_ok(tag_t tag, data_t value);
    return exp_val[tag] === value;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      live        <= '0;
      seen_accept <= 1'b0;
    end else begin
      if (cdb_valid) live[cdb_tag] <= 1'b0;   // tag freed by its broadcast
      if (accept) begin
        live[inst_tag] <= 1'b1;
        seen_accept    <= 1'b1;
      end
    end
  end

  a_quiet_start: assert property (@(posedge clock) disable iff (reset)
    !seen_accept |-> !cdb_valid)
    else begin
      err_count++;
      $error("cdb_valid went high before any instruction was accepted");
    end

  // completion order is free, the value is not
  a_cdb_value: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> value_ok(cdb_tag, cdb_value))
    else begin
      err_count++;
      $error("mismatch at %0t: cdb_value for tag %0d expected %h got %h", $time,
             $sampled(cdb_tag), exp_val[$sampled(cdb_tag)], $sampled(cdb_value));
    end

  a_cdb_once: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> live[cdb_tag])
    else begin
      err_count++;
      $error("tag %0d broadcast while not in flight", $sampled(cdb_tag));
    end

  a_tag_fresh: assert property (@(posedge clock) disable iff (reset)
    accept |-> !live[inst_tag])
    else begin
      err_count++;
      $error("inst_tag %0d handed out while still in flight", $sampled(inst_tag));
    end

endmodule

bind ooo_core_top ooo_core_props u_props (.*);

// File: ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              inst_valid,
  input  isa_pkg::op_t      inst_op,
  input  isa_pkg::reg_idx_t inst_dest,
  input  isa_pkg::reg_idx_t inst_src1,
  input  isa_pkg::reg_idx_t inst_src2,
  output logic              inst_stall,
  output rs_pkg::tag_t      inst_tag,
  output logic              cdb_valid,
  output rs_pkg::tag_t      cdb_tag,
  output isa_pkg::data_t    cdb_value
);

  dispatch_if dsp ();   // rename to station
  issue_if    iss ();   // station to units

  rename_dispatch u_rename (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_op    (inst_op),
    .inst_dest  (inst_dest),
    .inst_src1  (inst_src1),
    .inst_src2  (inst_src2),
    .inst_stall (inst_stall),
    .inst_tag   (inst_tag),
    .cdb_valid  (cdb_valid),    // frees tags, updates regs
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value),
    .dsp        (dsp.producer)
  );

  reservation_station u_rs (
    .clock     (clock),
    .reset     (reset),
    .dsp       (dsp.station),
    .iss       (iss.station),
    .cdb_valid (cdb_valid),     // operand wake-up
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

  exec_units u_exec (
    .clock     (clock),
    .reset     (reset),
    .iss       (iss.units),
    .cdb_valid (cdb_valid),     // single bus driver
    .cdb_tag   (cdb_tag),
    .cdb_value (cdb_value)
  );

endmodule

// File: exec_units.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module exec_units (
  input  logic            clock,
  input  logic            reset,
  issue_if.units          iss,
  output logic            cdb_valid,
  output rs_pkg::tag_t    cdb_tag,
  output isa_pkg::data_t  cdb_value
);
  import isa_pkg::*;
  import rs_pkg::*;

  localparam int NUM_ALU = `OOO_NUM_RS - 1;      // units 0..NUM_ALU-1
  localparam int MU      = `OOO_NUM_RS - 1;      // multiplier lane
  localparam int CNT_W   = $clog2(`OOO_MUL_LAT + 1);

  // ALU result holding registers
  logic [NUM_ALU-1:0] alu_full;
  tag_t               alu_tag [NUM_ALU];
  data_t              alu_val [NUM_ALU];
  logic [NUM_ALU-1:0] alu_grant;

  // multiplier, one op at a time
  mul_state_t         mul_state;
  logic [CNT_W-1:0]   mul_cnt;
  tag_t               mul_tag;
  data_t              mul_a, mul_b;
  data_t              mul_val;
  logic               mul_grant;

  // fixed priority, mul then alu0 then alu1
  always_comb begin
    mul_grant = 1'b0;
    alu_grant = '0;
    cdb_valid = 1'b0;
    cdb_tag   = mul_tag;
    cdb_value = mul_val;
    if (mul_state == MUL_DONE) begin
      mul_grant = 1'b1;
      cdb_valid = 1'b1;
    end
    for (int u = 0; u < NUM_ALU; u++) begin
      if (alu_full[u] && !cdb_valid) begin
        alu_grant[u] = 1'b1;
        cdb_valid    = 1'b1;
        cdb_tag      = alu_tag[u];
        cdb_value    = alu_val[u];
      end
    end
  end

  // a unit with an unsent result stalls, unless it drains this cycle
  always_comb begin
    for (int u = 0; u < NUM_ALU; u++) begin
      iss.issue_ack[u] = !alu_full[u] || alu_grant[u];
    end
    iss.issue_ack[MU] = (mul_state == MUL_IDLE) || mul_grant;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_full  <= '0;
      mul_state <= MUL_IDLE;
    end else begin
      for (int u = 0; u < NUM_ALU; u++) begin
        if (iss.issue_req[u] && iss.issue_ack[u]) begin
          alu_full[u] <= 1'b1;                 // held one cycle after accept
          alu_tag[u]  <= iss.issue_tag[u];
          alu_val[u]  <= alu_result(iss.issue_op[u], iss.issue_a[u], iss.issue_b[u]);
        end else if (alu_grant[u]) begin
          alu_full[u] <= 1'b0;
        end
      end
      case (mul_state)
        MUL_BUSY: begin
          if (mul_cnt == '0) begin
            mul_state <= MUL_DONE;
            mul_val   <= mul_a * mul_b;        // keeps the low half
          end else begin
            mul_cnt <= mul_cnt - 1'b1;
          end
        end
        MUL_DONE: if (mul_grant) mul_state <= MUL_IDLE;
        default: ;
      endcase
      // accept in idle, or back to back as the old result leaves
      if (iss.issue_req[MU] && iss.issue_ack[MU]) begin
        mul_state <= MUL_BUSY;
        mul_cnt   <= CNT_W'(`OOO_MUL_LAT - 2);   // held OOO_MUL_LAT cycles after accept
        mul_tag   <= iss.issue_tag[MU];
        mul_a     <= iss.issue_a[MU];
        mul_b     <= iss.issue_b[MU];
      end
    end
  end

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module reservation_station (
  input  logic           clock,
  input  logic           reset,
  dispatch_if.station    dsp,
  issue_if.station       iss,
  input  logic           cdb_valid,
  input  rs_pkg::tag_t   cdb_tag,
  input  isa_pkg::data_t cdb_value
);
  import isa_pkg::*;
  import rs_pkg::*;

  localparam int N = `OOO_NUM_RS;

  // entry state, entry i is wired to unit i
  logic [N-1:0] busy;
  op_t          e_op   [N];
  tag_t         e_dest [N];
  logic [N-1:0] s1_rdy;
  tag_t         s1_tag [N];
  data_t        s1_val [N];
  logic [N-1:0] s2_rdy;
  tag_t         s2_tag [N];
  data_t        s2_val [N];

  logic [N-1:0] s1_cdb;       // src1 tag on the bus
  logic [N-1:0] s2_cdb;       // src2 matched on its own tag
  logic [N-1:0] issue_fire;   // leaves this cycle
  logic [N-1:0] entry_free;
  logic [N-1:0] entry_match;  // free and right kind
  rs_idx_t      dsp_idx;      // lowest matching entry
  logic         dsp_fire;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      s1_cdb[i]      = busy[i] && !s1_rdy[i] && cdb_valid && s1_tag[i] == cdb_tag;
      s2_cdb[i]      = busy[i] && !s2_rdy[i] && cdb_valid && s2_tag[i] == cdb_tag;
      issue_fire[i]  = iss.issue_req[i] && iss.issue_ack[i];
      entry_free[i]  = !busy[i] || issue_fire[i];   // slot reusable at this edge
      entry_match[i] = entry_free[i] && unit_kind(rs_idx_t'(i)) == op_kind(dsp.op);
    end
  end

  // priority pick, lowest index
  always_comb begin
    dsp_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (entry_match[i]) begin
        dsp_idx = rs_idx_t'(i);
      end
    end
  end

  assign dsp.rs_hazard = entry_match == '0;
  assign dsp_fire      = dsp.dispatch_en && !dsp.rs_hazard;

  // issue from registered readiness, the cycle after the last capture
  always_comb begin
    for (int i = 0; i < N; i++) begin
      iss.issue_req[i] = busy[i] && s1_rdy[i] && s2_rdy[i];
      iss.issue_op[i]  = e_op[i];
      iss.issue_tag[i] = e_dest[i];
      iss.issue_a[i]   = s1_val[i];
      iss.issue_b[i]   = s2_val[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy   <= '0;
      s1_rdy <= '0;
      s2_rdy <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (s1_cdb[i]) begin          // snoop the bus every cycle
          s1_rdy[i] <= 1'b1;
          s1_val[i] <= cdb_value;
        end
        if (s2_cdb[i]) begin
          s2_rdy[i] <= 1'b1;
          s2_val[i] <= cdb_value;
        end
        if (issue_fire[i]) begin
          busy[i] <= 1'b0;
        end
        // refill wins over the issue clear of the same entry
        if (dsp_fire && dsp_idx == rs_idx_t'(i)) begin
          busy[i]   <= 1'b1;
          e_op[i]   <= dsp.op;
          e_dest[i] <= dsp.dest_tag;
          s1_rdy[i] <= dsp.src1_ready;
          s1_tag[i] <= dsp.src1_tag;
          s1_val[i] <= dsp.src1_value;
          s2_rdy[i] <= dsp.src2_ready;
          s2_tag[i] <= dsp.src2_tag;
          s2_val[i] <= dsp.src2_value;
        end
      end
    end
  end

endmodule

// File: rename_dispatch.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module rename_dispatch (
  input  logic              clock,
  input  logic              reset,
  input  logic              inst_valid,
  input  isa_pkg::op_t      inst_op,
  input  isa_pkg::reg_idx_t inst_dest,
  input  isa_pkg::reg_idx_t inst_src1,
  input  isa_pkg::reg_idx_t inst_src2,
  output logic              inst_stall,
  output rs_pkg::tag_t      inst_tag,
  input  logic              cdb_valid,
  input  rs_pkg::tag_t      cdb_tag,
  input  isa_pkg::data_t    cdb_value,
  dispatch_if.producer      dsp
);
  import isa_pkg::*;
  import rs_pkg::*;

  // register status table
  data_t                    reg_value [`OOO_NUM_REGS];   // committed value
  logic [`OOO_NUM_REGS-1:0] reg_pend;                    // waiting on a writer
  tag_t                     reg_tag   [`OOO_NUM_REGS];   // latest writer's tag

  logic [`OOO_NUM_TAGS-1:0] tag_busy;   // tag in flight
  tag_t                     free_tag;
  logic                     tag_avail;
  logic                     accept;

  reg_idx_t src_reg [2];
  logic     src_rdy [2];
  tag_t     src_tag [2];
  data_t    src_val [2];

  // lowest free tag wins, scan from the top
  always_comb begin
    tag_avail = 1'b0;
    free_tag  = '0;
    for (int t = `OOO_NUM_TAGS - 1; t >= 0; t--) begin
      if (!tag_busy[t]) begin
        tag_avail = 1'b1;
        free_tag  = tag_t'(t);
      end
    end
  end

  // source lookup, value if known, else tag unless it is on the CDB now
  always_comb begin
    src_reg[0] = inst_src1;
    src_reg[1] = inst_src2;
    for (int s = 0; s < 2; s++) begin
      src_tag[s] = reg_tag[src_reg[s]];
      if (!reg_pend[src_reg[s]]) begin
        src_rdy[s] = 1'b1;
        src_val[s] = reg_value[src_reg[s]];
      end else if (cdb_valid && cdb_tag == src_tag[s]) begin
        src_rdy[s] = 1'b1;                 // same-cycle forward
        src_val[s] = cdb_value;
      end else begin
        src_rdy[s] = 1'b0;
        src_val[s] = '0;
      end
    end
  end

  assign inst_stall = !tag_avail || dsp.rs_hazard;
  assign inst_tag   = free_tag;
  assign accept     = inst_valid && !inst_stall;

  assign dsp.dispatch_en = inst_valid && tag_avail;   // station adds its own hazard
  assign dsp.op          = inst_op;
  assign dsp.dest_tag    = free_tag;
  assign dsp.src1_ready  = src_rdy[0];
  assign dsp.src1_tag    = src_tag[0];
  assign dsp.src1_value  = src_val[0];
  assign dsp.src2_ready  = src_rdy[1];
  assign dsp.src2_tag    = src_tag[1];
  assign dsp.src2_value  = src_val[1];

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_busy <= '0;
      reg_pend <= '0;
      for (int r = 0; r < `OOO_NUM_REGS; r++) begin
        reg_value[r] <= data_t'(r);   // register i starts at i
      end
    end else begin
      if (cdb_valid) begin
        tag_busy[cdb_tag] <= 1'b0;    // name returns at broadcast
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
          // older writers lose, only the newest tag updates the reg
          if (reg_pend[r] && reg_tag[r] == cdb_tag) begin
            reg_value[r] <= cdb_value;
            reg_pend[r]  <= 1'b0;
          end
        end
      end
      if (accept) begin               // after the CDB so a new writer wins
        tag_busy[free_tag]  <= 1'b1;
        reg_pend[inst_dest] <= 1'b1;
        reg_tag[inst_dest]  <= free_tag;
      end
    end
  end

endmodule

// File: issue_if.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

interface issue_if;
  import isa_pkg::*;
  import rs_pkg::*;

  // one lane per unit, lane index == entry index
  logic [`OOO_NUM_RS-1:0] issue_req;    // entry holds both operands
  logic [`OOO_NUM_RS-1:0] issue_ack;    // unit can take it this cycle
  op_t   issue_op  [`OOO_NUM_RS];
  tag_t  issue_tag [`OOO_NUM_RS];       // destination name
  data_t issue_a   [`OOO_NUM_RS];
  data_t issue_b   [`OOO_NUM_RS];

  modport station (
    output issue_req,
    output issue_op,
    output issue_tag,
    output issue_a,
    output issue_b,
    input  issue_ack
  );

  modport units (
    input  issue_req,
    input  issue_op,
    input  issue_tag,
    input  issue_a,
    input  issue_b,
    output issue_ack
  );

endinterface

// File: dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if;
  import isa_pkg::*;
  import rs_pkg::*;

  logic  dispatch_en;    // renamed instruction offered
  op_t   op;
  tag_t  dest_tag;       // name of the result
  logic  src1_ready;     // value valid, else wait on tag
  tag_t  src1_tag;
  data_t src1_value;
  logic  src2_ready;
  tag_t  src2_tag;
  data_t src2_value;
  logic  rs_hazard;      // no entry of this op's kind can take it

  modport producer (
    output dispatch_en, op, dest_tag,
    output src1_ready, src1_tag, src1_value,
    output src2_ready, src2_tag, src2_value,
    input  rs_hazard
  );

  modport station (
    input  dispatch_en, op, dest_tag,
    input  src1_ready, src1_tag, src1_value,
    input  src2_ready, src2_tag, src2_value,
    output rs_hazard
  );

endinterface

// File: rs_pkg.sv
`include "ooo_config.svh"

package rs_pkg;

  // name of an in-flight result
  typedef logic [`OOO_TAG_W-1:0] tag_t;

  // station entry or unit number
  typedef logic [`OOO_RS_W-1:0] rs_idx_t;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_kind_t;

  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_BUSY = 2'd1,
    MUL_DONE = 2'd2   // result held until it wins the CDB
  } mul_state_t;

  // entries 0..N-2 feed ALUs, the last one feeds the multiplier
  function automatic fu_kind_t unit_kind(rs_idx_t idx);
    return (idx == rs_idx_t'(`OOO_NUM_RS - 1)) ? FU_MUL : FU_ALU;
  endfunction

  // kind of unit an op needs
  function automatic fu_kind_t op_kind(isa_pkg::op_t op);
    return (op == isa_pkg::OP_MUL) ? FU_MUL : FU_ALU;
  endfunction

endpackage

// File: isa_pkg.sv
`include "ooo_config.svh"

package isa_pkg;

  // architectural register number
  typedef logic [`OOO_REG_W-1:0] reg_idx_t;

  // operand or result word, all arithmetic wraps
  typedef logic [`OOO_DATA_W-1:0] data_t;

  // integer operations of the core
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_MUL = 3'd4   // low half of the product
  } op_t;

  // one-cycle ALU result for the four ALU ops
  function automatic data_t alu_result(op_t op, data_t a, data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return '0;    // mul never reaches an ALU
    endcase
  endfunction

endpackage

// File: ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// architectural register file
`define OOO_NUM_REGS 8
`define OOO_REG_W    3     // log2 of OOO_NUM_REGS

// in-flight result names
`define OOO_NUM_TAGS 16
`define OOO_TAG_W    4     // log2 of OOO_NUM_TAGS

// station entries, one per functional unit
`define OOO_NUM_RS   3
`define OOO_RS_W     2

`define OOO_DATA_W   16    // operand and result width
`define OOO_MUL_LAT  3     // cycles from mul accept to held result

`endif
